//--- verilog/net_msg_pkg.sv
//--------------------------------------------------
// ring network message format
// field widths and the packed message layout
//--------------------------------------------------

package net_msg_pkg;

  // field widths
  localparam int c_srcdest_nbits = 3;
  localparam int c_opaque_nbits  = 3;
  localparam int c_payload_nbits = 32;

  typedef logic [c_srcdest_nbits-1:0] net_addr_t;

  // dest sits in the top bits so routing can slice it off the head
  typedef struct packed {
    net_addr_t                  dest;
    net_addr_t                  src;
    logic [c_opaque_nbits-1:0]  opaque;
    logic [c_payload_nbits-1:0] payload;
  } net_msg_t;

endpackage

//--- verilog/router_pkg.sv
//--------------------------------------------------
// router port naming and terminal routing helper
//--------------------------------------------------

package router_pkg;

  localparam int c_num_ports = 3;

  typedef enum logic [1:0] {
    port_west = 2'd0,
    port_term = 2'd1,
    port_east = 2'd2
  } port_t;

  // shortest way around the ring, east wins a tie
  function automatic port_t route_term(input net_msg_pkg::net_addr_t dest,
                                       input int router_id,
                                       input int num_routers);
    int fwd;
    fwd = (int'(dest) - router_id + num_routers) % num_routers;
    if (int'(dest) == router_id) return port_term;
    if (fwd <= num_routers / 2) return port_east;
    return port_west;
  endfunction

endpackage

//--- verilog/net_queue.sv
//--------------------------------------------------
// two-entry register queue
// valid/ready on both sides, no bypass path
//--------------------------------------------------

`timescale 1ns/1ns

module net_queue #(
  parameter int p_msg_nbits = 41
) (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   enq_val,
  output logic                   enq_rdy,
  input  logic [p_msg_nbits-1:0] enq_msg,

  output logic                   deq_val,
  input  logic                   deq_rdy,
  output logic [p_msg_nbits-1:0] deq_msg
);

  logic [p_msg_nbits-1:0] entries [2];
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             count;
  logic                   do_enq;
  logic                   do_deq;

  // ready only looks at occupancy
  assign enq_rdy = (count != 2'd2);
  assign deq_val = (count != 2'd0);
  assign do_enq  = enq_val && enq_rdy;
  assign do_deq  = deq_val && deq_rdy;
  assign deq_msg = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (do_enq)
        wr_ptr <= ~wr_ptr;
      if (do_deq)
        rd_ptr <= ~rd_ptr;
      count <= count + 2'(do_enq) - 2'(do_deq);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_enq)
      entries[wr_ptr] <= enq_msg;
  end

endmodule

//--- verilog/ring_input_ctrl.sv
//--------------------------------------------------
// ring port input control
// two domain queues, domain pick and route request
//--------------------------------------------------

`timescale 1ns/1ns

module ring_input_ctrl #(
  parameter int p_router_id = 0
) (
  input  logic                               clk,
  input  logic                               reset,

  input  logic                               val_d1,
  output logic                               rdy_d1,
  input  net_msg_pkg::net_msg_t              msg_d1,

  input  logic                               val_d2,
  output logic                               rdy_d2,
  input  net_msg_pkg::net_msg_t              msg_d2,

  input  router_pkg::port_t                  pass_port,
  output logic [router_pkg::c_num_ports-1:0] reqs,
  input  logic [router_pkg::c_num_ports-1:0] grants,
  output net_msg_pkg::net_msg_t              head_msg,
  output logic                               head_domain
);

  import net_msg_pkg::*;
  import router_pkg::*;

  net_msg_t deq_msg_d1;
  net_msg_t deq_msg_d2;
  logic     deq_val_d1;
  logic     deq_val_d2;
  logic     deq_rdy_d1;
  logic     deq_rdy_d2;
  logic     fresh_sel;
  logic     sel;
  logic     head_val;
  logic     deq;
  logic     prio;
  logic     hold;
  logic     held_sel;
  port_t    route;

  net_queue #(.p_msg_nbits($bits(net_msg_t))) queue_d1 (
    .clk     (clk),
    .reset   (reset),
    .enq_val (val_d1),
    .enq_rdy (rdy_d1),
    .enq_msg (msg_d1),
    .deq_val (deq_val_d1),
    .deq_rdy (deq_rdy_d1),
    .deq_msg (deq_msg_d1)
  );

  net_queue #(.p_msg_nbits($bits(net_msg_t))) queue_d2 (
    .clk     (clk),
    .reset   (reset),
    .enq_val (val_d2),
    .enq_rdy (rdy_d2),
    .enq_msg (msg_d2),
    .deq_val (deq_val_d2),
    .deq_rdy (deq_rdy_d2),
    .deq_msg (deq_msg_d2)
  );

  //--------------------------------------------------
  // domain select
  //--------------------------------------------------

  // prio high favours d2 when both heads wait
  assign fresh_sel = deq_val_d2 && (!deq_val_d1 || prio);
  // a waiting head keeps its domain until it leaves
  assign sel         = hold ? held_sel : fresh_sel;
  assign head_val    = sel ? deq_val_d2 : deq_val_d1;
  assign head_msg    = sel ? deq_msg_d2 : deq_msg_d1;
  assign head_domain = sel;

  // local dest leaves on the terminal, all else keeps going
  assign route = (head_msg.dest == net_addr_t'(p_router_id)) ? port_term : pass_port;

  always_comb begin
    reqs = '0;
    if (head_val)
      reqs[route] = 1'b1;
  end

  assign deq        = |grants;
  assign deq_rdy_d1 = deq && !sel;
  assign deq_rdy_d2 = deq && sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      prio     <= 1'b0;
      hold     <= 1'b0;
      held_sel <= 1'b0;
    end else begin
      if (deq)
        prio <= ~prio;
      hold     <= head_val && !deq;
      held_sel <= sel;
    end
  end

endmodule

//--- verilog/term_input_ctrl.sv
//--------------------------------------------------
// terminal input control
// queue with domain bit, shortest-way route request
//--------------------------------------------------

`timescale 1ns/1ns

module term_input_ctrl #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 8
) (
  input  logic                               clk,
  input  logic                               reset,

  input  logic                               val,
  output logic                               rdy,
  input  net_msg_pkg::net_msg_t              msg,
  input  logic                               domain,

  output logic [router_pkg::c_num_ports-1:0] reqs,
  input  logic [router_pkg::c_num_ports-1:0] grants,
  output net_msg_pkg::net_msg_t              head_msg,
  output logic                               head_domain
);

  import net_msg_pkg::*;
  import router_pkg::*;

  // domain bit rides above the message
  localparam int c_entry_nbits = $bits(net_msg_t) + 1;

  logic [c_entry_nbits-1:0] deq_entry;
  logic                     deq_val;
  port_t                    route;

  net_queue #(.p_msg_nbits(c_entry_nbits)) queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (val),
    .enq_rdy (rdy),
    .enq_msg ({domain, msg}),
    .deq_val (deq_val),
    .deq_rdy (|grants),
    .deq_msg (deq_entry)
  );

  assign head_domain = deq_entry[c_entry_nbits-1];
  assign head_msg    = deq_entry[c_entry_nbits-2:0];
  assign route       = route_term(head_msg.dest, p_router_id, p_num_routers);

  always_comb begin
    reqs = '0;
    if (deq_val)
      reqs[route] = 1'b1;
  end

endmodule

//--- verilog/output_arbiter.sv
//--------------------------------------------------
// output port arbiter
// round-robin grant, message mux and domain flag
//--------------------------------------------------

`timescale 1ns/1ns

module output_arbiter (
  input  logic                               clk,
  input  logic                               reset,

  input  logic [router_pkg::c_num_ports-1:0] reqs,
  output logic [router_pkg::c_num_ports-1:0] grants,

  input  net_msg_pkg::net_msg_t              msgs_west,
  input  net_msg_pkg::net_msg_t              msgs_term,
  input  net_msg_pkg::net_msg_t              msgs_east,
  input  logic [router_pkg::c_num_ports-1:0] domains,

  output logic                               out_val,
  input  logic                               out_rdy,
  output net_msg_pkg::net_msg_t              out_msg,
  output logic                               out_domain
);

  import router_pkg::*;

  port_t ptr;
  port_t rr_winner;
  port_t winner;
  port_t held_winner;
  logic  hold;
  logic  xfer;

  // search from ptr, the nearest requester wins
  always_comb begin
    int idx;
    rr_winner = ptr;
    for (int i = c_num_ports - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % c_num_ports;
      if (reqs[idx])
        rr_winner = port_t'(idx);
    end
  end

  // keep the stalled winner so the output holds still
  assign winner  = hold ? held_winner : rr_winner;
  assign out_val = |reqs;
  assign xfer    = out_val && out_rdy;

  always_comb begin
    grants = '0;
    if (xfer)
      grants[winner] = 1'b1;
  end

  //--------------------------------------------------
  // crossbar leg
  //--------------------------------------------------

  always_comb begin
    case (winner)
      port_term: out_msg = msgs_term;
      port_east: out_msg = msgs_east;
      default:   out_msg = msgs_west;
    endcase
  end

  assign out_domain = domains[winner];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr         <= port_west;
      hold        <= 1'b0;
      held_winner <= port_west;
    end else begin
      hold        <= out_val && !out_rdy;
      held_winner <= winner;
      // next search starts just past the winner
      if (xfer) begin
        case (winner)
          port_west: ptr <= port_term;
          port_term: ptr <= port_east;
          default:   ptr <= port_west;
        endcase
      end
    end
  end

endmodule

//--- verilog/ring_router.sv
//--------------------------------------------------
// three-port ring router
// west and east ring ports with two domains each
//--------------------------------------------------

`timescale 1ns/1ns

module ring_router #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 8
) (
  input  logic                  clk,
  input  logic                  reset,

  input  logic                  in0_val_d1,
  output logic                  in0_rdy_d1,
  input  net_msg_pkg::net_msg_t in0_msg_d1,
  input  logic                  in0_val_d2,
  output logic                  in0_rdy_d2,
  input  net_msg_pkg::net_msg_t in0_msg_d2,

  input  logic                  in1_val,
  output logic                  in1_rdy,
  input  net_msg_pkg::net_msg_t in1_msg,
  input  logic                  in1_domain,

  input  logic                  in2_val_d1,
  output logic                  in2_rdy_d1,
  input  net_msg_pkg::net_msg_t in2_msg_d1,
  input  logic                  in2_val_d2,
  output logic                  in2_rdy_d2,
  input  net_msg_pkg::net_msg_t in2_msg_d2,

  output logic                  out0_val,
  input  logic                  out0_rdy,
  output net_msg_pkg::net_msg_t out0_msg,
  output logic                  out0_domain,

  output logic                  out1_val,
  input  logic                  out1_rdy,
  output net_msg_pkg::net_msg_t out1_msg,
  output logic                  out1_domain,

  output logic                  out2_val,
  input  logic                  out2_rdy,
  output net_msg_pkg::net_msg_t out2_msg,
  output logic                  out2_domain
);

  import net_msg_pkg::*;
  import router_pkg::*;

  logic [c_num_ports-1:0] in0_reqs;
  logic [c_num_ports-1:0] in1_reqs;
  logic [c_num_ports-1:0] in2_reqs;
  logic [c_num_ports-1:0] in0_grants;
  logic [c_num_ports-1:0] in1_grants;
  logic [c_num_ports-1:0] in2_grants;
  logic [c_num_ports-1:0] out0_reqs;
  logic [c_num_ports-1:0] out1_reqs;
  logic [c_num_ports-1:0] out2_reqs;
  logic [c_num_ports-1:0] out0_grants;
  logic [c_num_ports-1:0] out1_grants;
  logic [c_num_ports-1:0] out2_grants;
  logic [c_num_ports-1:0] head_domains;
  net_msg_t               in0_head_msg;
  net_msg_t               in1_head_msg;
  net_msg_t               in2_head_msg;
  logic                   in0_head_domain;
  logic                   in1_head_domain;
  logic                   in2_head_domain;

  //--------------------------------------------------
  // input controls
  //--------------------------------------------------

  ring_input_ctrl #(.p_router_id(p_router_id)) in0_ctrl (
    .clk         (clk),
    .reset       (reset),
    .val_d1      (in0_val_d1),
    .rdy_d1      (in0_rdy_d1),
    .msg_d1      (in0_msg_d1),
    .val_d2      (in0_val_d2),
    .rdy_d2      (in0_rdy_d2),
    .msg_d2      (in0_msg_d2),
    .pass_port   (port_east),
    .reqs        (in0_reqs),
    .grants      (in0_grants),
    .head_msg    (in0_head_msg),
    .head_domain (in0_head_domain)
  );

  term_input_ctrl #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers)
  ) in1_ctrl (
    .clk         (clk),
    .reset       (reset),
    .val         (in1_val),
    .rdy         (in1_rdy),
    .msg         (in1_msg),
    .domain      (in1_domain),
    .reqs        (in1_reqs),
    .grants      (in1_grants),
    .head_msg    (in1_head_msg),
    .head_domain (in1_head_domain)
  );

  ring_input_ctrl #(.p_router_id(p_router_id)) in2_ctrl (
    .clk         (clk),
    .reset       (reset),
    .val_d1      (in2_val_d1),
    .rdy_d1      (in2_rdy_d1),
    .msg_d1      (in2_msg_d1),
    .val_d2      (in2_val_d2),
    .rdy_d2      (in2_rdy_d2),
    .msg_d2      (in2_msg_d2),
    .pass_port   (port_west),
    .reqs        (in2_reqs),
    .grants      (in2_grants),
    .head_msg    (in2_head_msg),
    .head_domain (in2_head_domain)
  );

  // transpose so output k sees bit k of every input
  assign out0_reqs = {in2_reqs[0], in1_reqs[0], in0_reqs[0]};
  assign out1_reqs = {in2_reqs[1], in1_reqs[1], in0_reqs[1]};
  assign out2_reqs = {in2_reqs[2], in1_reqs[2], in0_reqs[2]};

  assign in0_grants = {out2_grants[0], out1_grants[0], out0_grants[0]};
  assign in1_grants = {out2_grants[1], out1_grants[1], out0_grants[1]};
  assign in2_grants = {out2_grants[2], out1_grants[2], out0_grants[2]};

  assign head_domains = {in2_head_domain, in1_head_domain, in0_head_domain};

  //--------------------------------------------------
  // output arbiters
  //--------------------------------------------------

  output_arbiter out0_arb (
    .clk        (clk),
    .reset      (reset),
    .reqs       (out0_reqs),
    .grants     (out0_grants),
    .msgs_west  (in0_head_msg),
    .msgs_term  (in1_head_msg),
    .msgs_east  (in2_head_msg),
    .domains    (head_domains),
    .out_val    (out0_val),
    .out_rdy    (out0_rdy),
    .out_msg    (out0_msg),
    .out_domain (out0_domain)
  );

  output_arbiter out1_arb (
    .clk        (clk),
    .reset      (reset),
    .reqs       (out1_reqs),
    .grants     (out1_grants),
    .msgs_west  (in0_head_msg),
    .msgs_term  (in1_head_msg),
    .msgs_east  (in2_head_msg),
    .domains    (head_domains),
    .out_val    (out1_val),
    .out_rdy    (out1_rdy),
    .out_msg    (out1_msg),
    .out_domain (out1_domain)
  );

  output_arbiter out2_arb (
    .clk        (clk),
    .reset      (reset),
    .reqs       (out2_reqs),
    .grants     (out2_grants),
    .msgs_west  (in0_head_msg),
    .msgs_term  (in1_head_msg),
    .msgs_east  (in2_head_msg),
    .domains    (head_domains),
    .out_val    (out2_val),
    .out_rdy    (out2_rdy),
    .out_msg    (out2_msg),
    .out_domain (out2_domain)
  );

endmodule

//--- sim/router_tb.sv
//--------------------------------------------------
// ring router testbench
// random traffic, reference queues and assertions
//--------------------------------------------------

`timescale 1ns/1ns

module router_tb;

  import net_msg_pkg::*;

  localparam int c_router_id   = 5;
  localparam int c_num_routers = 8;
  localparam int c_period      = 100;
  localparam int c_sample_at   = 40;
  localparam int c_timeout     = 3000;

  typedef enum {mode_local, mode_pass, mode_term, mode_mixed, mode_fair} mode_t;

  // channels 0/1 are in0 d1/d2, 2 is the terminal, 3/4 are in2 d1/d2
  logic        clk;
  logic        reset;
  logic        ch_val [5];
  logic        ch_rdy [5];
  net_msg_t    ch_msg [5];
  logic        term_domain;
  logic        out_val [3];
  logic        out_rdy [3];
  net_msg_t    out_msg [3];
  logic        out_domain [3];

  // expected messages per output, input and domain
  net_msg_t    exp_q [18][$];
  logic        accepted [5];
  logic        prev_stall [3];
  net_msg_t    prev_msg [3];
  logic        prev_dom [3];
  int          wait_cnt [3];
  logic [31:0] lfsr;
  mode_t       mode;
  logic        random_rdy;
  logic        fair_check;
  int          to_send;
  int          seq;
  int          errors;
  int          timeouts;
  int          checked;
  int          accepted_total;

  ring_router #(
    .p_router_id   (c_router_id),
    .p_num_routers (c_num_routers)
  ) dut0 (
    .clk         (clk),
    .reset       (reset),
    .in0_val_d1  (ch_val[0]),
    .in0_rdy_d1  (ch_rdy[0]),
    .in0_msg_d1  (ch_msg[0]),
    .in0_val_d2  (ch_val[1]),
    .in0_rdy_d2  (ch_rdy[1]),
    .in0_msg_d2  (ch_msg[1]),
    .in1_val     (ch_val[2]),
    .in1_rdy     (ch_rdy[2]),
    .in1_msg     (ch_msg[2]),
    .in1_domain  (term_domain),
    .in2_val_d1  (ch_val[3]),
    .in2_rdy_d1  (ch_rdy[3]),
    .in2_msg_d1  (ch_msg[3]),
    .in2_val_d2  (ch_val[4]),
    .in2_rdy_d2  (ch_rdy[4]),
    .in2_msg_d2  (ch_msg[4]),
    .out0_val    (out_val[0]),
    .out0_rdy    (out_rdy[0]),
    .out0_msg    (out_msg[0]),
    .out0_domain (out_domain[0]),
    .out1_val    (out_val[1]),
    .out1_rdy    (out_rdy[1]),
    .out1_msg    (out_msg[1]),
    .out1_domain (out_domain[1]),
    .out2_val    (out_val[2]),
    .out2_rdy    (out_rdy[2]),
    .out2_msg    (out_msg[2]),
    .out2_domain (out_domain[2])
  );

  initial begin
    clk = 1'b0;
    forever #(c_period / 2) clk = ~clk;
  end

  //--------------------------------------------------
  // helpers
  //--------------------------------------------------

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic int chan_input(input int ch);
    if (ch < 2)
      return 0;
    if (ch == 2)
      return 1;
    return 2;
  endfunction

  function automatic int qidx(input int out_idx, input int in_idx, input logic dom);
    return (out_idx * 3 + in_idx) * 2 + int'(dom);
  endfunction

  // 0 west, 1 terminal, 2 east
  function automatic int expected_port(input int in_idx, input net_addr_t dest);
    int hops;
    hops = 0;
    // walk east from this router and count the hops up to dest
    for (int h = 0; h < c_num_routers; h++) begin
      if ((c_router_id + h) % c_num_routers == int'(dest))
        hops = h;
    end
    if (int'(dest) == c_router_id)
      return 1;
    if (in_idx == 0)
      return 2;
    if (in_idx == 2)
      return 0;
    // terminal goes the shorter way and east on a tie
    if (hops <= c_num_routers / 2)
      return 2;
    return 0;
  endfunction

  function automatic logic channel_on(input int ch);
    case (mode)
      mode_local, mode_pass: return ch != 2;
      mode_term:             return ch == 2;
      mode_fair:             return ch == 0 || ch == 2 || ch == 3;
      default:               return 1'b1;
    endcase
  endfunction

  function automatic net_addr_t pick_dest();
    net_addr_t dest;
    if (mode == mode_local || mode == mode_fair)
      return net_addr_t'(c_router_id);
    dest = net_addr_t'(take_bits(c_srcdest_nbits));
    if (mode == mode_pass && int'(dest) == c_router_id)
      dest = dest ^ net_addr_t'(1);
    return dest;
  endfunction

  // payload top bits name the source so the monitor finds its queue
  function automatic net_msg_t make_msg(input int in_idx, input logic dom);
    net_msg_t    msg;
    logic [31:0] bits;
    msg.dest    = pick_dest();
    bits        = take_bits(c_srcdest_nbits);
    msg.src     = bits[c_srcdest_nbits-1:0];
    bits        = take_bits(c_opaque_nbits);
    msg.opaque  = bits[c_opaque_nbits-1:0];
    msg.payload = {2'(in_idx), dom, 29'(seq)};
    seq++;
    return msg;
  endfunction

  function automatic logic all_drained();
    for (int ch = 0; ch < 5; ch++) begin
      if (ch_val[ch])
        return 1'b0;
    end
    for (int i = 0; i < 18; i++) begin
      if (exp_q[i].size() > 0)
        return 1'b0;
    end
    return to_send == 0;
  endfunction

  task automatic log_error(input string text);
    errors++;
    $display("** Error at %0t ns: %s", $time, text);
  endtask

  task automatic check_idle();
    for (int k = 0; k < 3; k++) begin
      assert (!out_val[k])
        else log_error($sformatf("out%0d valid around reset", k));
    end
    for (int ch = 0; ch < 5; ch++) begin
      assert (ch_rdy[ch])
        else log_error($sformatf("input channel %0d not ready around reset", ch));
    end
  endtask

  //--------------------------------------------------
  // stimulus
  //--------------------------------------------------

  task automatic drive_cycle();
    logic [31:0] bits;
    logic        dom;
    @(negedge clk);
    for (int ch = 0; ch < 5; ch++) begin
      if (ch_val[ch] && accepted[ch])
        ch_val[ch] = 1'b0;
      if (!ch_val[ch] && to_send > 0 && channel_on(ch)) begin
        bits = take_bits(2);
        if (mode == mode_fair || bits[1:0] != 2'b00) begin
          dom = (ch == 1 || ch == 4);
          if (ch == 2) begin
            bits        = take_bits(1);
            term_domain = bits[0];
            dom         = bits[0];
          end
          ch_msg[ch] = make_msg(chan_input(ch), dom);
          ch_val[ch] = 1'b1;
          to_send--;
        end
      end
    end
    for (int k = 0; k < 3; k++) begin
      bits       = take_bits(2);
      out_rdy[k] = !random_rdy || bits[1:0] != 2'b00;
    end
  endtask

  task automatic run_phase(input mode_t phase_mode, input int count, input logic rdy_random);
    int   cycles;
    logic idle;
    mode       = phase_mode;
    to_send    = count;
    random_rdy = rdy_random;
    cycles     = 0;
    idle       = 1'b0;
    while (!idle && cycles < c_timeout) begin
      drive_cycle();
      cycles++;
      idle = all_drained();
    end
    if (!idle) begin
      $display("timeout: %s traffic still in flight after %0d cycles",
               phase_mode.name(), cycles);
      timeouts++;
    end
  endtask

  //--------------------------------------------------
  // monitor and reference model
  //--------------------------------------------------

  task automatic sample_cycle();
    int       src_in;
    int       idx;
    logic     src_dom;
    logic     found;
    net_msg_t exp_msg;
    // outputs go before inputs because nothing bypasses a queue
    for (int k = 0; k < 3; k++) begin
      if (prev_stall[k]) begin
        assert (out_val[k] && out_msg[k] == prev_msg[k] && out_domain[k] == prev_dom[k])
          else log_error($sformatf("out%0d changed while stalled", k));
      end
      if (out_val[k] && out_rdy[k]) begin
        src_in  = int'(out_msg[k].payload[31:30]);
        src_dom = out_msg[k].payload[29];
        idx     = qidx(k, src_in, src_dom);
        found   = (src_in < 3) && (exp_q[idx].size() > 0);
        assert (found)
          else log_error($sformatf("out%0d sent %h, nothing expected from in%0d dom %0d",
                                   k, out_msg[k], src_in, src_dom));
        assert (out_domain[k] == src_dom)
          else log_error($sformatf("out%0d domain %0d, expected %0d",
                                   k, out_domain[k], src_dom));
        if (found) begin
          exp_msg = exp_q[idx].pop_front();
          checked++;
          assert (out_msg[k] == exp_msg)
            else log_error($sformatf("out%0d message %h, expected %h",
                                     k, out_msg[k], exp_msg));
          if (k == 1 && fair_check) begin
            for (int i = 0; i < 3; i++) begin
              if (i != src_in &&
                  (exp_q[qidx(1, i, 0)].size() > 0 || exp_q[qidx(1, i, 1)].size() > 0)) begin
                wait_cnt[i]++;
                assert (wait_cnt[i] <= 2)
                  else log_error($sformatf("in%0d passed over %0d times on out1",
                                           i, wait_cnt[i]));
              end
            end
            wait_cnt[src_in] = 0;
          end
        end
      end
      prev_stall[k] = out_val[k] && !out_rdy[k];
      prev_msg[k]   = out_msg[k];
      prev_dom[k]   = out_domain[k];
    end
    for (int ch = 0; ch < 5; ch++) begin
      accepted[ch] = ch_val[ch] && ch_rdy[ch];
      if (accepted[ch]) begin
        src_in  = chan_input(ch);
        src_dom = (ch == 2) ? term_domain : (ch == 1 || ch == 4);
        idx     = qidx(expected_port(src_in, ch_msg[ch].dest), src_in, src_dom);
        exp_q[idx].push_back(ch_msg[ch]);
        accepted_total++;
      end
    end
  endtask

  // sample well after the falling edge drive and before the rising edge
  always @(negedge clk) begin
    #(c_sample_at);
    if (reset) begin
      for (int ch = 0; ch < 5; ch++)
        accepted[ch] = 1'b0;
      for (int k = 0; k < 3; k++)
        prev_stall[k] = 1'b0;
    end else begin
      sample_cycle();
    end
  end

  //--------------------------------------------------
  // main sequence
  //--------------------------------------------------

  initial begin
    lfsr           = 32'hd30c_078b;
    reset          = 1'b1;
    term_domain    = 1'b0;
    mode           = mode_local;
    random_rdy     = 1'b0;
    fair_check     = 1'b0;
    to_send        = 0;
    seq            = 0;
    errors         = 0;
    timeouts       = 0;
    checked        = 0;
    accepted_total = 0;
    for (int ch = 0; ch < 5; ch++) begin
      ch_val[ch]   = 1'b0;
      ch_msg[ch]   = '0;
      accepted[ch] = 1'b0;
    end
    for (int k = 0; k < 3; k++) begin
      out_rdy[k]    = 1'b1;
      prev_stall[k] = 1'b0;
      wait_cnt[k]   = 0;
    end

    // eight rising edges in reset and a last check on the first free cycle
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      if (i == 7)
        reset = 1'b0;
      #10;
      check_idle();
    end

    run_phase(mode_local, 40, 1'b0);
    if (timeouts == 0)
      run_phase(mode_pass, 40, 1'b0);
    if (timeouts == 0)
      run_phase(mode_term, 60, 1'b0);
    if (timeouts == 0)
      run_phase(mode_mixed, 300, 1'b1);
    if (timeouts == 0) begin
      fair_check = 1'b1;
      run_phase(mode_fair, 90, 1'b0);
      fair_check = 1'b0;
    end

    $display("errors: %0d  timeouts: %0d  checked: %0d  accepted: %0d",
             errors, timeouts, checked, accepted_total);
    if (errors == 0 && timeouts == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- sim.f
verilog/net_msg_pkg.sv
verilog/router_pkg.sv
verilog/net_queue.sv
verilog/ring_input_ctrl.sv
verilog/term_input_ctrl.sv
verilog/output_arbiter.sv
verilog/ring_router.sv
sim/router_tb.sv

//--- Makefile
# Verilator build and run of the ring router testbench

BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module router_tb \
		-f sim.f --Mdir $(BUILD_DIR) -o router_sim
	$(BUILD_DIR)/router_sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf $(BUILD_DIR) sim.log
